//--- cce_msg_unit.f
cce_msg_pkg.sv
cce_mem_resp_fwd.sv
cce_inv_sharers.sv
cce_msg_ctrl.sv
cce_msg_unit.sv
tb_cce_msg_unit.sv

//--- Bender.yml
package:
  name: cce_msg_unit

sources:
  - files:
      - cce_msg_pkg.sv
      - cce_mem_resp_fwd.sv
      - cce_inv_sharers.sv
      - cce_msg_ctrl.sv
      - cce_msg_unit.sv
  - target: test
    files:
      - tb_cce_msg_unit.sv

//--- tb_cce_msg_unit.sv
// CCE message unit testbench
`timescale 1ns/100ps
`default_nettype none

module tb_cce_msg_unit;

  localparam int num_tests   = 300;
  localparam int cycle_limit = num_tests * 40;

  logic                    clk_i;
  logic                    reset_i;
  cce_msg_pkg::lce_id_t    cce_id_i;
  cce_msg_pkg::mem_resp_s  mem_resp_i;
  logic                    mem_resp_v_i;
  logic                    mem_resp_yumi_o;
  cce_msg_pkg::lce_resp_s  lce_resp_i;
  logic                    lce_resp_v_i;
  logic                    lce_resp_yumi_o;
  cce_msg_pkg::inv_req_s   inv_req_i;
  logic                    inv_req_v_i;
  logic                    inv_req_yumi_o;
  cce_msg_pkg::lce_cmd_s   lce_cmd_o;
  logic                    lce_cmd_v_o;
  logic                    lce_cmd_ready_i;
  logic                    pending_w_v_o;
  cce_msg_pkg::pending_w_s pending_w_o;
  logic                    dir_w_v_o;
  cce_msg_pkg::dir_w_s     dir_w_o;
  logic                    inv_busy_o;

  // xorshift state
  logic [31:0] rng_state;

  // stimulus queues, the head is what the DUT sees
  cce_msg_pkg::mem_resp_s mem_q[$];
  cce_msg_pkg::lce_resp_s lce_q[$];
  cce_msg_pkg::inv_req_s  req_item;
  logic mem_pres;
  logic lce_pres;
  logic req_pres;

  // reference model of the invalidation sequence
  cce_msg_pkg::inv_state_e m_state;
  cce_msg_pkg::sharers_t   m_left;
  cce_msg_pkg::inv_req_s   m_req;
  int m_cnt;

  // run bookkeeping and event counts
  int cycle_cnt;
  int issued;
  int n_fill;
  int n_uc_rd;
  int n_uc_wr;
  int n_wb;
  int n_coh;
  int n_inv_send;
  int n_inv_empty;
  int n_inv_done;

  cce_msg_unit i_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cce_id_i        (cce_id_i),
    .mem_resp_i      (mem_resp_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_yumi_o (mem_resp_yumi_o),
    .lce_resp_i      (lce_resp_i),
    .lce_resp_v_i    (lce_resp_v_i),
    .lce_resp_yumi_o (lce_resp_yumi_o),
    .inv_req_i       (inv_req_i),
    .inv_req_v_i     (inv_req_v_i),
    .inv_req_yumi_o  (inv_req_yumi_o),
    .lce_cmd_o       (lce_cmd_o),
    .lce_cmd_v_o     (lce_cmd_v_o),
    .lce_cmd_ready_i (lce_cmd_ready_i),
    .pending_w_v_o   (pending_w_v_o),
    .pending_w_o     (pending_w_o),
    .dir_w_v_o       (dir_w_v_o),
    .dir_w_o         (dir_w_o),
    .inv_busy_o      (inv_busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // set index lives right above the byte offset
  function automatic cce_msg_pkg::set_idx_t set_of(cce_msg_pkg::paddr_t a);
    return a[cce_msg_pkg::block_offset_width +: cce_msg_pkg::set_width];
  endfunction

  // command expected for a response that needs the port
  function automatic cce_msg_pkg::lce_cmd_s expect_fwd(cce_msg_pkg::mem_resp_s r,
                                                      cce_msg_pkg::lce_id_t src);
    cce_msg_pkg::lce_cmd_s c;
    c        = '0;
    c.dst_id = r.lce_id;
    c.addr   = r.addr;
    if (r.msg_type == cce_msg_pkg::e_mem_uc_rd) begin
      c.msg_type = cce_msg_pkg::e_lce_cmd_uc_data;
      c.data[cce_msg_pkg::dword_width-1:0] = r.data[cce_msg_pkg::dword_width-1:0];
    end else if (r.msg_type == cce_msg_pkg::e_mem_uc_wr) begin
      c.msg_type = cce_msg_pkg::e_lce_cmd_uc_st_done;
      c.src_id   = src;
    end else begin
      c.msg_type = cce_msg_pkg::e_lce_cmd_data;
      c.way_id   = r.way_id;
      c.state    = r.state;
      c.data     = r.data;
    end
    return c;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_cmd(input cce_msg_pkg::lce_cmd_s got, input cce_msg_pkg::lce_cmd_s exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] lce_cmd_o: got %h, expected %h", got, exp));
    end
  endtask

  task automatic check_pending(input cce_msg_pkg::pending_w_s got,
                               input cce_msg_pkg::pending_w_s exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] pending_w_o: got %h, expected %h", got, exp));
    end
  endtask

  task automatic check_dir(input cce_msg_pkg::dir_w_s got, input cce_msg_pkg::dir_w_s exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] dir_w_o: got %h, expected %h", got, exp));
    end
  endtask

  // new random work, plus random first presentation of queued items
  task automatic add_stimulus();
    logic [31:0] pick;
    cce_msg_pkg::mem_resp_s m;
    cce_msg_pkg::lce_resp_s l;
    if (issued < num_tests && next_rand() % 4 == 0) begin
      pick = next_rand() % 8;
      if (pick == 7 && !req_pres) begin
        req_item.req_lce = cce_msg_pkg::lce_id_t'(next_rand());
        req_item.addr    = next_rand();
        // a quarter of the requests have only the requester as sharer
        if (next_rand() % 4 == 0) begin
          req_item.sharers = '0;
          req_item.sharers[req_item.req_lce] = 1'b1;
        end else begin
          req_item.sharers = cce_msg_pkg::sharers_t'(next_rand());
        end
        for (int i = 0; i < cce_msg_pkg::num_lce; i++) begin
          req_item.ways[i] = cce_msg_pkg::way_id_t'(next_rand());
        end
        req_pres = 1'b1;
      end else if (pick >= 5) begin
        l.src_id   = cce_msg_pkg::lce_id_t'(next_rand());
        l.msg_type = cce_msg_pkg::e_lce_resp_coh_ack;
        l.addr     = next_rand();
        lce_q.push_back(l);
      end else begin
        m.msg_type = cce_msg_pkg::mem_msg_e'(next_rand() % 5);
        m.addr     = next_rand();
        m.lce_id   = cce_msg_pkg::lce_id_t'(next_rand());
        m.way_id   = cce_msg_pkg::way_id_t'(next_rand());
        m.state    = cce_msg_pkg::coh_state_e'(next_rand() % 5);
        m.data     = {next_rand(), next_rand(), next_rand(), next_rand()};
        mem_q.push_back(m);
      end
      issued++;
    end
    if (!mem_pres && mem_q.size() > 0 && (next_rand() & 1)) mem_pres = 1'b1;
    if (!lce_pres && lce_q.size() > 0 && (next_rand() & 1)) lce_pres = 1'b1;
  endtask

  task automatic drive_inputs();
    mem_resp_v_i    = mem_pres;
    lce_resp_v_i    = lce_pres;
    inv_req_v_i     = req_pres;
    inv_req_i       = req_item;
    lce_cmd_ready_i = (next_rand() % 4 != 0);
    if (mem_pres) mem_resp_i = mem_q[0];
    if (lce_pres) lce_resp_i = lce_q[0];
  endtask

  // compare this cycle's outputs, then step the model
  task automatic check_cycle();
    cce_msg_pkg::lce_cmd_s   exp_cmd;
    cce_msg_pkg::pending_w_s exp_pend;
    cce_msg_pkg::dir_w_s     exp_dir;
    cce_msg_pkg::lce_resp_s  ack;
    cce_msg_pkg::lce_id_t    dst;
    logic needs;
    logic closes;
    logic found;
    logic mem_take;
    logic mem_pend;
    logic coh_take;
    logic ack_take;
    logic inv_v;
    logic inv_take;
    logic left_empty;
    needs  = 1'b0;
    closes = 1'b0;
    if (mem_resp_v_i) begin
      case (mem_resp_i.msg_type)
        cce_msg_pkg::e_mem_rd,
        cce_msg_pkg::e_mem_wr: begin
          needs  = 1'b1;
          closes = 1'b1;
        end
        cce_msg_pkg::e_mem_uc_rd,
        cce_msg_pkg::e_mem_uc_wr: needs = 1'b1;
        cce_msg_pkg::e_mem_wb: closes = 1'b1;
        default: needs = 1'b0;
      endcase
    end
    mem_take = mem_resp_v_i && (!needs || lce_cmd_ready_i);
    mem_pend = mem_take && closes;
    coh_take = lce_resp_v_i && lce_resp_i.msg_type == cce_msg_pkg::e_lce_resp_coh_ack
               && !mem_pend;
    ack_take = lce_resp_v_i && lce_resp_i.msg_type == cce_msg_pkg::e_lce_resp_inv_ack
               && m_state != cce_msg_pkg::e_inv_ready;
    // lowest remaining sharer is next
    dst   = '0;
    found = 1'b0;
    for (int i = 0; i < cce_msg_pkg::num_lce; i++) begin
      if (m_left[i] && !found) begin
        dst   = cce_msg_pkg::lce_id_t'(i);
        found = 1'b1;
      end
    end
    left_empty = !found;
    inv_v    = m_state == cce_msg_pkg::e_inv_cmd && found && !needs;
    inv_take = inv_v && lce_cmd_ready_i;

    check_bit("mem_resp_yumi_o", mem_resp_yumi_o, mem_take);
    check_bit("lce_resp_yumi_o", lce_resp_yumi_o, coh_take || ack_take);
    check_bit("inv_req_yumi_o", inv_req_yumi_o, m_state == cce_msg_pkg::e_inv_ready && inv_req_v_i);
    check_bit("lce_cmd_v_o", lce_cmd_v_o, needs || inv_v);
    check_bit("pending_w_v_o", pending_w_v_o, mem_pend || coh_take);
    check_bit("dir_w_v_o", dir_w_v_o, inv_take);
    check_bit("inv_busy_o", inv_busy_o, m_state != cce_msg_pkg::e_inv_ready);
    if (needs) begin
      check_cmd(lce_cmd_o, expect_fwd(mem_resp_i, cce_id_i));
    end else if (inv_v) begin
      exp_cmd          = '0;
      exp_cmd.dst_id   = dst;
      exp_cmd.msg_type = cce_msg_pkg::e_lce_cmd_invalidate;
      exp_cmd.way_id   = m_req.ways[dst];
      exp_cmd.addr     = m_req.addr;
      exp_cmd.state    = cce_msg_pkg::e_coh_i;
      exp_cmd.src_id   = cce_id_i;
      check_cmd(lce_cmd_o, exp_cmd);
    end
    if (mem_pend || coh_take) begin
      exp_pend.set     = mem_pend ? set_of(mem_resp_i.addr) : set_of(lce_resp_i.addr);
      exp_pend.pending = 1'b0;
      check_pending(pending_w_o, exp_pend);
    end
    if (inv_take) begin
      exp_dir.lce_id = dst;
      exp_dir.way_id = m_req.ways[dst];
      check_dir(dir_w_o, exp_dir);
    end

    // consumed items leave their queues
    if (mem_take) begin
      case (mem_resp_i.msg_type)
        cce_msg_pkg::e_mem_uc_rd: n_uc_rd++;
        cce_msg_pkg::e_mem_uc_wr: n_uc_wr++;
        cce_msg_pkg::e_mem_wb:    n_wb++;
        default:                  n_fill++;
      endcase
      void'(mem_q.pop_front());
      mem_pres = 1'b0;
    end
    if (coh_take || ack_take) begin
      if (coh_take) n_coh++;
      void'(lce_q.pop_front());
      lce_pres = 1'b0;
    end
    // the invalidated LCE answers later with an inv-ack
    if (inv_take) begin
      ack.src_id   = dst;
      ack.msg_type = cce_msg_pkg::e_lce_resp_inv_ack;
      ack.addr     = m_req.addr;
      lce_q.push_back(ack);
      m_left[dst] = 1'b0;
      n_inv_send++;
    end
    case (m_state)
      cce_msg_pkg::e_inv_ready: begin
        if (inv_req_v_i) begin
          m_req  = inv_req_i;
          m_left = inv_req_i.sharers;
          m_left[inv_req_i.req_lce] = 1'b0;
          if (m_left == '0) n_inv_empty++;
          m_cnt    = 0;
          m_state  = cce_msg_pkg::e_inv_cmd;
          req_pres = 1'b0;
        end
      end
      cce_msg_pkg::e_inv_cmd: begin
        m_cnt = m_cnt + int'(inv_take) - int'(ack_take);
        if (left_empty) m_state = cce_msg_pkg::e_inv_resp;
      end
      default: begin
        m_cnt = m_cnt - int'(ack_take);
        if (m_cnt == 0) begin
          m_state = cce_msg_pkg::e_inv_ready;
          n_inv_done++;
        end
      end
    endcase
  endtask

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    rng_state       = 32'd90;
    reset_i         = 1'b1;
    cce_id_i        = 2'd2;
    mem_resp_i      = '0;
    mem_resp_v_i    = 1'b0;
    lce_resp_i      = '0;
    lce_resp_v_i    = 1'b0;
    inv_req_i       = '0;
    inv_req_v_i     = 1'b0;
    lce_cmd_ready_i = 1'b0;
    req_item        = '0;
    mem_pres        = 1'b0;
    lce_pres        = 1'b0;
    req_pres        = 1'b0;
    m_state         = cce_msg_pkg::e_inv_ready;
    m_left          = '0;
    m_req           = '0;
    m_cnt           = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #5;
    // idle outputs straight out of reset
    check_bit("mem_resp_yumi_o", mem_resp_yumi_o, 1'b0);
    check_bit("lce_resp_yumi_o", lce_resp_yumi_o, 1'b0);
    check_bit("inv_req_yumi_o", inv_req_yumi_o, 1'b0);
    check_bit("lce_cmd_v_o", lce_cmd_v_o, 1'b0);
    check_bit("pending_w_v_o", pending_w_v_o, 1'b0);
    check_bit("dir_w_v_o", dir_w_v_o, 1'b0);
    check_bit("inv_busy_o", inv_busy_o, 1'b0);

    while (issued < num_tests || mem_q.size() > 0 || lce_q.size() > 0 || req_pres
           || m_state != cce_msg_pkg::e_inv_ready) begin
      @(negedge clk_i);
      add_stimulus();
      drive_inputs();
      #5;
      check_cycle();
    end

    if (n_fill == 0 || n_uc_rd == 0 || n_uc_wr == 0 || n_wb == 0 || n_coh == 0
        || n_inv_send == 0 || n_inv_empty == 0 || n_inv_done == 0) begin
      abort_run("random stimulus missed at least one kind of transaction");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- cce_msg_unit.sv
// CCE message unit top
`timescale 1ns/100ps
`default_nettype none

module cce_msg_unit (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  cce_msg_pkg::lce_id_t    cce_id_i,
  // memory responses
  input  cce_msg_pkg::mem_resp_s  mem_resp_i,
  input  logic                    mem_resp_v_i,
  output logic                    mem_resp_yumi_o,
  // LCE responses
  input  cce_msg_pkg::lce_resp_s  lce_resp_i,
  input  logic                    lce_resp_v_i,
  output logic                    lce_resp_yumi_o,
  // invalidation requests
  input  cce_msg_pkg::inv_req_s   inv_req_i,
  input  logic                    inv_req_v_i,
  output logic                    inv_req_yumi_o,
  // LCE commands
  output cce_msg_pkg::lce_cmd_s   lce_cmd_o,
  output logic                    lce_cmd_v_o,
  input  logic                    lce_cmd_ready_i,
  // pending bits and directory
  output logic                    pending_w_v_o,
  output cce_msg_pkg::pending_w_s pending_w_o,
  output logic                    dir_w_v_o,
  output cce_msg_pkg::dir_w_s     dir_w_o,
  output logic                    inv_busy_o
);

  cce_msg_pkg::lce_cmd_s fwd_cmd;
  cce_msg_pkg::lce_cmd_s inv_cmd;
  cce_msg_pkg::set_idx_t fwd_set;
  cce_msg_pkg::lce_id_t  inv_dst;
  cce_msg_pkg::way_id_t  inv_way;
  cce_msg_pkg::paddr_t   inv_addr_r;

  logic needs_cmd;
  logic clears_pending;
  logic cmd_sel_inv;
  logic pending_from_resp;
  logic any_sharer;
  logic load;
  logic advance;

  cce_mem_resp_fwd i_fwd (
    .mem_resp_i       (mem_resp_i),
    .cce_id_i         (cce_id_i),
    .lce_cmd_o        (fwd_cmd),
    .needs_cmd_o      (needs_cmd),
    .clears_pending_o (clears_pending),
    .pending_set_o    (fwd_set)
  );

  cce_inv_sharers i_sharers (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .load_i    (load),
    .inv_req_i (inv_req_i),
    .advance_i (advance),
    .dst_o     (inv_dst),
    .way_o     (inv_way),
    .any_o     (any_sharer)
  );

  cce_msg_ctrl i_ctrl (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .mem_resp_v_i        (mem_resp_v_i),
    .needs_cmd_i         (needs_cmd),
    .clears_pending_i    (clears_pending),
    .mem_resp_yumi_o     (mem_resp_yumi_o),
    .lce_resp_v_i        (lce_resp_v_i),
    .lce_resp_type_i     (lce_resp_i.msg_type),
    .lce_resp_yumi_o     (lce_resp_yumi_o),
    .inv_req_v_i         (inv_req_v_i),
    .inv_req_yumi_o      (inv_req_yumi_o),
    .lce_cmd_ready_i     (lce_cmd_ready_i),
    .lce_cmd_v_o         (lce_cmd_v_o),
    .cmd_sel_inv_o       (cmd_sel_inv),
    .pending_w_v_o       (pending_w_v_o),
    .pending_from_resp_o (pending_from_resp),
    .dir_w_v_o           (dir_w_v_o),
    .any_sharer_i        (any_sharer),
    .load_o              (load),
    .advance_o           (advance),
    .inv_busy_o          (inv_busy_o)
  );

  // request address is needed for every invalidate of the sequence
  always_ff @(posedge clk_i) begin
    if (load) begin
      inv_addr_r <= inv_req_i.addr;
    end
  end

  always_comb begin
    inv_cmd          = '0;
    inv_cmd.dst_id   = inv_dst;
    inv_cmd.msg_type = cce_msg_pkg::e_lce_cmd_invalidate;
    inv_cmd.way_id   = inv_way;
    inv_cmd.addr     = inv_addr_r;
    inv_cmd.state    = cce_msg_pkg::e_coh_i;
    inv_cmd.src_id   = cce_id_i;
  end

  assign lce_cmd_o = cmd_sel_inv ? inv_cmd : fwd_cmd;

  // only clears are issued here
  assign pending_w_o.set     = pending_from_resp ? cce_msg_pkg::addr_to_set(lce_resp_i.addr)
                                                 : fwd_set;
  assign pending_w_o.pending = 1'b0;

  // directory entry of the LCE just invalidated
  assign dir_w_o.lce_id = inv_dst;
  assign dir_w_o.way_id = inv_way;

endmodule

`default_nettype wire

//--- cce_msg_ctrl.sv
// CCE message unit control
`timescale 1ns/100ps
`default_nettype none

module cce_msg_ctrl (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // memory response side
  input  logic                   mem_resp_v_i,
  input  logic                   needs_cmd_i,
  input  logic                   clears_pending_i,
  output logic                   mem_resp_yumi_o,
  // LCE response side
  input  logic                   lce_resp_v_i,
  input  cce_msg_pkg::lce_resp_e lce_resp_type_i,
  output logic                   lce_resp_yumi_o,
  // invalidation request side
  input  logic                   inv_req_v_i,
  output logic                   inv_req_yumi_o,
  // LCE command port
  input  logic                   lce_cmd_ready_i,
  output logic                   lce_cmd_v_o,
  output logic                   cmd_sel_inv_o,
  // pending and directory write ports
  output logic                   pending_w_v_o,
  output logic                   pending_from_resp_o,
  output logic                   dir_w_v_o,
  // sharer list
  input  logic                   any_sharer_i,
  output logic                   load_o,
  output logic                   advance_o,
  output logic                   inv_busy_o
);

  cce_msg_pkg::inv_state_e state_r;
  cce_msg_pkg::inv_state_e state_n;
  cce_msg_pkg::ack_cnt_t   cnt_r;
  cce_msg_pkg::ack_cnt_t   cnt_n;

  logic mem_cmd_busy;
  logic mem_fire;
  logic mem_pend_w;
  logic coh_ack_yumi;
  logic inv_ack_yumi;
  logic inv_offer;
  logic inv_send;

  // memory response owns the command port whenever it needs it
  assign mem_cmd_busy = mem_resp_v_i & needs_cmd_i;

  // writebacks go in one cycle, others wait for the command port
  assign mem_fire   = mem_resp_v_i & (~needs_cmd_i | lce_cmd_ready_i);
  assign mem_pend_w = mem_fire & clears_pending_i;

  assign mem_resp_yumi_o = mem_fire;

  // coh_ack yields the pending port to a closing memory response
  assign coh_ack_yumi = lce_resp_v_i
                      & (lce_resp_type_i == cce_msg_pkg::e_lce_resp_coh_ack)
                      & ~mem_pend_w;

  // inv-acks only drain while a sequence is running
  assign inv_ack_yumi = lce_resp_v_i
                      & (lce_resp_type_i == cce_msg_pkg::e_lce_resp_inv_ack)
                      & (state_r != cce_msg_pkg::e_inv_ready);

  assign lce_resp_yumi_o = coh_ack_yumi | inv_ack_yumi;

  assign pending_w_v_o       = mem_pend_w | coh_ack_yumi;
  assign pending_from_resp_o = coh_ack_yumi;

  // invalidate offered only when memory is not using the port
  assign inv_offer = (state_r == cce_msg_pkg::e_inv_cmd) & any_sharer_i & ~mem_cmd_busy;
  assign inv_send  = inv_offer & lce_cmd_ready_i;

  assign lce_cmd_v_o   = mem_cmd_busy | inv_offer;
  assign cmd_sel_inv_o = inv_offer;

  // directory update and list advance happen on the accepted send
  assign dir_w_v_o = inv_send;
  assign advance_o = inv_send;

  // new request taken on its first valid cycle in ready
  assign inv_req_yumi_o = (state_r == cce_msg_pkg::e_inv_ready) & inv_req_v_i;
  assign load_o         = inv_req_yumi_o;

  assign inv_busy_o = (state_r != cce_msg_pkg::e_inv_ready);

  always_comb begin
    state_n = state_r;
    cnt_n   = cnt_r;

    case (state_r)
      cce_msg_pkg::e_inv_ready: begin
        if (inv_req_v_i) begin
          state_n = cce_msg_pkg::e_inv_cmd;
          cnt_n   = '0;
        end
      end

      cce_msg_pkg::e_inv_cmd: begin
        // a send and an ack in one cycle cancel out
        cnt_n = cnt_r + cce_msg_pkg::ack_cnt_t'(inv_send)
                      - cce_msg_pkg::ack_cnt_t'(inv_ack_yumi);
        // an empty list also lands here, so no hang
        if (!any_sharer_i) begin
          state_n = cce_msg_pkg::e_inv_resp;
        end
      end

      cce_msg_pkg::e_inv_resp: begin
        cnt_n = cnt_r - cce_msg_pkg::ack_cnt_t'(inv_ack_yumi);
        // done once every ack is back, including this cycle's
        if (cnt_n == '0) begin
          state_n = cce_msg_pkg::e_inv_ready;
        end
      end

      default: begin
        state_n = cce_msg_pkg::e_inv_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cce_msg_pkg::e_inv_ready;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      cnt_r   <= cnt_n;
    end
  end

endmodule

`default_nettype wire

//--- cce_inv_sharers.sv
// Invalidation sharer list
`timescale 1ns/100ps
`default_nettype none

module cce_inv_sharers (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  load_i,
  input  cce_msg_pkg::inv_req_s inv_req_i,
  input  logic                  advance_i,
  output cce_msg_pkg::lce_id_t  dst_o,
  output cce_msg_pkg::way_id_t  way_o,
  output logic                  any_o
);

  // remaining sharers still owed an invalidate
  cce_msg_pkg::sharers_t sharers_r;
  cce_msg_pkg::sharers_t sharers_n;
  cce_msg_pkg::sharers_t req_mask;
  cce_msg_pkg::sharers_t dst_mask;

  // way each LCE holds the block in
  cce_msg_pkg::way_id_t [cce_msg_pkg::num_lce-1:0] ways_r;

  // one-hot of the requester and of the current target
  assign req_mask = cce_msg_pkg::sharers_t'(1) << inv_req_i.req_lce;
  assign dst_mask = cce_msg_pkg::sharers_t'(1) << dst_o;

  // lowest-numbered sharer goes first
  always_comb begin
    dst_o = '0;
    for (int i = cce_msg_pkg::num_lce - 1; i >= 0; i--) begin
      if (sharers_r[i]) begin
        dst_o = cce_msg_pkg::lce_id_t'(i);
      end
    end
  end

  assign any_o = |sharers_r;
  assign way_o = ways_r[dst_o];

  always_comb begin
    sharers_n = sharers_r;
    if (load_i) begin
      // requester keeps its copy
      sharers_n = inv_req_i.sharers & ~req_mask;
    end else if (advance_i) begin
      // current target has been sent its invalidate
      sharers_n = sharers_r & ~dst_mask;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sharers_r <= '0;
    end else begin
      sharers_r <= sharers_n;
    end
  end

  // ways only matter while their sharer bit is set
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      ways_r <= inv_req_i.ways;
    end
  end

endmodule

`default_nettype wire

//--- cce_mem_resp_fwd.sv
// Memory response forwarding
`timescale 1ns/100ps
`default_nettype none

module cce_mem_resp_fwd (
  input  cce_msg_pkg::mem_resp_s mem_resp_i,
  input  cce_msg_pkg::lce_id_t   cce_id_i,
  output cce_msg_pkg::lce_cmd_s  lce_cmd_o,
  output logic                   needs_cmd_o,
  output logic                   clears_pending_o,
  output cce_msg_pkg::set_idx_t  pending_set_o
);

  // every transaction closes on the set of its address
  assign pending_set_o = cce_msg_pkg::addr_to_set(mem_resp_i.addr);

  always_comb begin
    // fields not listed for a type stay zero
    lce_cmd_o        = '0;
    needs_cmd_o      = 1'b0;
    clears_pending_o = 1'b0;

    // destination and address are common to all forwarded types
    lce_cmd_o.dst_id = mem_resp_i.lce_id;
    lce_cmd_o.addr   = mem_resp_i.addr;

    case (mem_resp_i.msg_type)
      // cached fills, whole block with the granted state
      cce_msg_pkg::e_mem_rd,
      cce_msg_pkg::e_mem_wr: begin
        needs_cmd_o        = 1'b1;
        clears_pending_o   = 1'b1;
        lce_cmd_o.msg_type = cce_msg_pkg::e_lce_cmd_data;
        lce_cmd_o.way_id   = mem_resp_i.way_id;
        lce_cmd_o.state    = mem_resp_i.state;
        lce_cmd_o.data     = mem_resp_i.data;
      end

      // uncached load, only the low dword carries data
      cce_msg_pkg::e_mem_uc_rd: begin
        needs_cmd_o        = 1'b1;
        lce_cmd_o.msg_type = cce_msg_pkg::e_lce_cmd_uc_data;
        lce_cmd_o.way_id   = '0;
        lce_cmd_o.data[0 +: cce_msg_pkg::dword_width] =
          mem_resp_i.data[0 +: cce_msg_pkg::dword_width];
      end

      // uncached store done, tells the LCE which directory answered
      cce_msg_pkg::e_mem_uc_wr: begin
        needs_cmd_o        = 1'b1;
        lce_cmd_o.msg_type = cce_msg_pkg::e_lce_cmd_uc_st_done;
        lce_cmd_o.way_id   = '0;
        lce_cmd_o.src_id   = cce_id_i;
      end

      // writeback ack, nothing goes to the LCE
      cce_msg_pkg::e_mem_wb: begin
        clears_pending_o = 1'b1;
      end

      // unknown codes are dropped without side effects
      default: begin
        needs_cmd_o      = 1'b0;
        clears_pending_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- cce_msg_pkg.sv
// CCE message unit definitions
`default_nettype none

package cce_msg_pkg;

  // system sizing
  localparam int num_lce            = 4;
  localparam int lce_assoc          = 8;
  localparam int paddr_width        = 32;
  localparam int block_width        = 128;
  localparam int dword_width        = 64;
  localparam int block_offset_width = 4;
  localparam int set_width          = 6;
  // counter must reach num_lce, so one extra code
  localparam int ack_cnt_width      = $clog2(num_lce + 1);

  typedef logic [$clog2(num_lce)-1:0]   lce_id_t;
  typedef logic [$clog2(lce_assoc)-1:0] way_id_t;
  typedef logic [paddr_width-1:0]       paddr_t;
  typedef logic [set_width-1:0]         set_idx_t;
  typedef logic [block_width-1:0]       block_t;
  typedef logic [num_lce-1:0]           sharers_t;
  typedef logic [ack_cnt_width-1:0]     ack_cnt_t;

  typedef enum logic [2:0] {
    e_coh_i,
    e_coh_s,
    e_coh_e,
    e_coh_m,
    e_coh_o
  } coh_state_e;

  // memory response kinds seen from the memory side
  typedef enum logic [2:0] {
    e_mem_rd,
    e_mem_wr,
    e_mem_uc_rd,
    e_mem_uc_wr,
    e_mem_wb
  } mem_msg_e;

  typedef enum logic [2:0] {
    e_lce_cmd_data,
    e_lce_cmd_uc_data,
    e_lce_cmd_uc_st_done,
    e_lce_cmd_invalidate
  } lce_cmd_e;

  typedef enum logic {
    e_lce_resp_coh_ack,
    e_lce_resp_inv_ack
  } lce_resp_e;

  typedef enum logic [1:0] {
    e_inv_ready,
    e_inv_cmd,
    e_inv_resp
  } inv_state_e;

  typedef struct packed {
    mem_msg_e   msg_type;
    paddr_t     addr;
    lce_id_t    lce_id;
    way_id_t    way_id;
    coh_state_e state;
    block_t     data;
  } mem_resp_s;

  typedef struct packed {
    lce_id_t    dst_id;
    lce_cmd_e   msg_type;
    way_id_t    way_id;
    paddr_t     addr;
    coh_state_e state;
    lce_id_t    src_id;
    block_t     data;
  } lce_cmd_s;

  typedef struct packed {
    lce_id_t   src_id;
    lce_resp_e msg_type;
    paddr_t    addr;
  } lce_resp_s;

  // ways holds one entry per LCE, indexed by LCE number
  typedef struct packed {
    lce_id_t                   req_lce;
    paddr_t                    addr;
    sharers_t                  sharers;
    way_id_t [num_lce-1:0]     ways;
  } inv_req_s;

  typedef struct packed {
    set_idx_t set;
    logic     pending;
  } pending_w_s;

  typedef struct packed {
    lce_id_t lce_id;
    way_id_t way_id;
  } dir_w_s;

  // set index sits right above the byte offset
  function automatic set_idx_t addr_to_set(paddr_t addr);
    return addr[block_offset_width +: set_width];
  endfunction

endpackage

`default_nettype wire
